//--- src.f
rtl/sample_store_pkg.sv
rtl/uart_rx.sv
rtl/sample_loader.sv
rtl/sample_packer.sv
rtl/sample_ram.sv
rtl/sample_reader.sv
rtl/sample_store.sv
testbench/tb_sample_store.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sample_store
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" $(LOG) || \
		(echo "Simulation ended without passing, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_sample_store.sv
`timescale 1ns/1ps

module tb_sample_store;
    import sample_store_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int MAX_COUNT      = 11;                       // Longest record.
    localparam int REC_COUNT [INSTRUMENT_COUNT] = '{3, 8, 11, 1};
    localparam int TOTAL_SAMPLES  = REC_COUNT[0] + REC_COUNT[1] + REC_COUNT[2] + REC_COUNT[3];
    localparam int BYTES_PER_LOAD = 3 * INSTRUMENT_COUNT + 2 * TOTAL_SAMPLES;
    localparam int EXTRA_BYTES    = 4;
    localparam int LOAD_WAIT      = 4 * CLKS_PER_BIT;         // Last stop bit to load_done.

    // Readback pairs cover a partial word, an exact word, a word plus remainder
    // and a single sample.
    localparam int NUM_READS = 14;
    localparam int RD_INSTR [NUM_READS] = '{0, 0, 0, 1, 1, 1, 2, 2, 2, 2, 2, 3, 2, 0};
    localparam int RD_INDEX [NUM_READS] = '{0, 1, 2, 0, 4, 7, 0, 3, 7, 8, 10, 0, 9, 0};

    localparam int UART_CYCLES    = (2 * BYTES_PER_LOAD + EXTRA_BYTES) * 10 * CLKS_PER_BIT;
    localparam int READ_CYCLES    = 3 * (NUM_READS + 3);
    localparam int TIMEOUT_CYCLES = 2 * (UART_CYCLES + READ_CYCLES + 2 * RESET_CYCLES);

    logic    clk = 1'b0;
    logic    rst;
    logic    uart_din;
    logic    load_done;
    logic    overrun;
    logic    rd_req;
    instr_t  rd_instr;
    count_t  rd_index;
    logic    rd_valid;
    sample_t rd_sample;

    sample_t expected [INSTRUMENT_COUNT][MAX_COUNT];
    integer  seed;
    int      cycle_count = 0;

    sample_store i_sample_store (
        .clk       (clk),
        .rst       (rst),
        .uart_din  (uart_din),
        .load_done (load_done),
        .overrun   (overrun),
        .rd_req    (rd_req),
        .rd_instr  (rd_instr),
        .rd_index  (rd_index),
        .rd_valid  (rd_valid),
        .rd_sample (rd_sample)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout reached after %0d cycles", cycle_count));
        end
    end

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // All stimulus changes 1 ns after a rising edge.
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        wait_cycles(RESET_CYCLES);
        rst = 1'b0;
        check_flag("load_done", load_done, 1'b0);
        check_flag("overrun", overrun, 1'b0);
        check_flag("rd_valid", rd_valid, 1'b0);
    endtask

    task automatic send_byte(input byte_t b);
        uart_din = 1'b0;                                      // Start bit.
        wait_cycles(CLKS_PER_BIT);
        for (int i = 0; i < 8; i++) begin
            uart_din = b[i];
            wait_cycles(CLKS_PER_BIT);
        end
        uart_din = 1'b1;                                      // Stop bit.
        wait_cycles(CLKS_PER_BIT);
    endtask

    task automatic fill_expected();
        logic [31:0] rnd;
        for (int i = 0; i < INSTRUMENT_COUNT; i++) begin
            for (int j = 0; j < REC_COUNT[i]; j++) begin
                rnd = $random(seed);
                expected[i][j] = rnd[15:0];
            end
        end
    endtask

    task automatic send_record_byte(input byte_t b);
        check_flag("load_done", load_done, 1'b0);             // Not done before the last byte.
        send_byte(b);
    endtask

    task automatic send_load();
        count_t cnt;
        for (int i = 0; i < INSTRUMENT_COUNT; i++) begin
            cnt = count_t'(REC_COUNT[i]);
            send_record_byte(cnt[7:0]);
            send_record_byte(cnt[15:8]);
            send_record_byte(cnt[23:16]);
            for (int j = 0; j < REC_COUNT[i]; j++) begin
                send_record_byte(expected[i][j][7:0]);
                send_record_byte(expected[i][j][15:8]);
            end
        end
    endtask

    task automatic wait_load_done();
        int n;
        n = 0;
        while (!load_done && n < LOAD_WAIT) begin
            wait_cycles(1);
            n++;
        end
        if (!load_done) begin
            abort_run("load_done did not rise after the last record was sent");
        end else begin
            check_flag("overrun", overrun, 1'b0);
        end
    endtask

    // One request per cycle; each result is due two cycles after its request.
    task automatic run_readback();
        int k;
        for (int c = 0; c < NUM_READS + 3; c++) begin
            k = c - 2;
            if (k >= 0 && k < NUM_READS) begin
                check_flag("rd_valid", rd_valid, 1'b1);
                check_sample($sformatf("rd_sample (instr %0d index %0d)",
                                       RD_INSTR[k], RD_INDEX[k]),
                             rd_sample, expected[RD_INSTR[k]][RD_INDEX[k]]);
            end else begin
                check_flag("rd_valid", rd_valid, 1'b0);
            end
            if (c < NUM_READS) begin
                rd_req   = 1'b1;
                rd_instr = instr_t'(RD_INSTR[c]);
                rd_index = count_t'(RD_INDEX[c]);
            end else begin
                rd_req   = 1'b0;
                rd_instr = '0;
                rd_index = '0;
            end
            wait_cycles(1);
        end
    endtask

    task automatic send_extra_bytes();
        logic [31:0] rnd;
        for (int i = 0; i < EXTRA_BYTES; i++) begin
            rnd = $random(seed);
            check_flag("load_done", load_done, 1'b1);
            send_byte(rnd[7:0]);
        end
        check_flag("load_done", load_done, 1'b1);
        check_flag("overrun", overrun, 1'b0);
    endtask

    initial begin
        seed     = 32'hd41d_c843;
        rst      = 1'b1;
        uart_din = 1'b1;                                      // Idle line.
        rd_req   = 1'b0;
        rd_instr = '0;
        rd_index = '0;

        apply_reset();
        fill_expected();
        send_load();
        wait_load_done();
        run_readback();

        send_extra_bytes();
        run_readback();

        // Reload with fresh values.
        apply_reset();
        fill_expected();
        send_load();
        wait_load_done();
        run_readback();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- rtl/sample_store.sv
`timescale 1ns/1ps

module sample_store (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      uart_din,
    output logic                      load_done,
    output logic                      overrun,
    input  logic                      rd_req,
    input  sample_store_pkg::instr_t  rd_instr,
    input  sample_store_pkg::count_t  rd_index,
    output logic                      rd_valid,
    output sample_store_pkg::sample_t rd_sample
);
    import sample_store_pkg::*;

    logic       byte_valid;
    byte_t      rx_byte;
    logic       sample_valid;
    sample_t    sample;
    logic       sample_end;
    logic       sample_final;
    logic       credit_return;
    word_addr_t offsets [INSTRUMENT_COUNT];
    logic       wr_en;
    word_addr_t wr_addr;
    word_t      wr_data;
    word_addr_t rd_addr;
    word_t      rd_word;

    uart_rx i_uart_rx (
        .clk        (clk),
        .rst        (rst),
        .rx         (uart_din),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte)
    );

    sample_loader i_sample_loader (
        .clk           (clk),
        .rst           (rst),
        .byte_valid    (byte_valid),
        .rx_byte       (rx_byte),
        .credit_return (credit_return),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .sample_end    (sample_end),
        .sample_final  (sample_final),
        .offsets       (offsets),
        .overrun       (overrun)
    );

    sample_packer i_sample_packer (
        .clk           (clk),
        .rst           (rst),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .sample_end    (sample_end),
        .sample_final  (sample_final),
        .credit_return (credit_return),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .store_done    (load_done)
    );

    sample_ram i_sample_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

    sample_reader i_sample_reader (
        .clk       (clk),
        .rst       (rst),
        .rd_req    (rd_req),
        .rd_instr  (rd_instr),
        .rd_index  (rd_index),
        .offsets   (offsets),
        .rd_addr   (rd_addr),
        .rd_word   (rd_word),
        .rd_valid  (rd_valid),
        .rd_sample (rd_sample)
    );

endmodule

//--- rtl/sample_reader.sv
`timescale 1ns/1ps

module sample_reader (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rd_req,
    input  sample_store_pkg::instr_t     rd_instr,
    input  sample_store_pkg::count_t     rd_index,
    input  sample_store_pkg::word_addr_t offsets [sample_store_pkg::INSTRUMENT_COUNT],
    output sample_store_pkg::word_addr_t rd_addr,
    input  sample_store_pkg::word_t      rd_word,
    output logic                         rd_valid,
    output sample_store_pkg::sample_t    rd_sample
);
    import sample_store_pkg::*;

    lane_t s1_lane;
    logic  s1_valid;

    // The RAM's read register holds the address for stage one.
    assign rd_addr = offsets[rd_instr] + word_addr_t'(rd_index >> LANE_W);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            s1_valid <= rd_req;
            rd_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_lane   <= rd_index[LANE_W-1:0];
        rd_sample <= rd_word[s1_lane*SAMPLE_W +: SAMPLE_W];
    end

endmodule

//--- rtl/sample_ram.sv
`timescale 1ns/1ps

module sample_ram (
    input  logic                         clk,
    input  logic                         wr_en,
    input  sample_store_pkg::word_addr_t wr_addr,
    input  sample_store_pkg::word_t      wr_data,
    input  sample_store_pkg::word_addr_t rd_addr,
    output sample_store_pkg::word_t      rd_word
);
    import sample_store_pkg::*;

    word_t mem [2**WORD_ADDR_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_word <= mem[rd_addr];                 // Old data on a same-address write.
    end

endmodule

//--- rtl/sample_packer.sv
`timescale 1ns/1ps

module sample_packer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         sample_valid,
    input  sample_store_pkg::sample_t    sample,
    input  logic                         sample_end,
    input  logic                         sample_final,
    output logic                         credit_return,
    output logic                         wr_en,
    output sample_store_pkg::word_addr_t wr_addr,
    output sample_store_pkg::word_t      wr_data,
    output logic                         store_done
);
    import sample_store_pkg::*;

    logic [SAMPLE_W+1:0]   fifo_mem [SAMPLE_CREDITS];   // {final, end, sample}.
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [CREDIT_W-1:0]   fifo_count;
    logic                  pop;
    sample_t               head_sample;
    logic                  head_end;
    logic                  head_final;
    lane_t                 lane_idx;
    word_t                 lanes;
    word_t                 fill_word;
    logic                  word_full;
    logic                  word_final;

    assign pop = (fifo_count != '0);
    assign {head_final, head_end, head_sample} = fifo_mem[rd_ptr];
    assign word_full = (lane_idx == lane_t'(SAMPLES_PER_WORD - 1)) || head_end;

    always_comb begin
        fill_word = lanes;
        fill_word[lane_idx*SAMPLE_W +: SAMPLE_W] = head_sample;
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            fifo_mem[wr_ptr] <= {sample_final, sample_end, sample};
        end
        if (pop && word_full) begin
            wr_data <= fill_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fifo_count    <= '0;
            credit_return <= 1'b0;
            lane_idx      <= '0;
            lanes         <= '0;                 // Unused lanes pad with zeros.
            wr_en         <= 1'b0;
            wr_addr       <= '0;
            word_final    <= 1'b0;
            store_done    <= 1'b0;
        end else begin
            credit_return <= pop;
            wr_en         <= 1'b0;
            fifo_count    <= fifo_count + CREDIT_W'(sample_valid) - CREDIT_W'(pop);
            if (sample_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
                if (word_final) begin
                    store_done <= 1'b1;
                end
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (word_full) begin
                    wr_en      <= 1'b1;
                    word_final <= head_final;
                    lanes      <= '0;
                    lane_idx   <= '0;
                end else begin
                    lanes    <= fill_word;
                    lane_idx <= lane_idx + 1'b1;
                end
            end
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> fifo_count != CREDIT_W'(SAMPLE_CREDITS));

endmodule

//--- rtl/sample_loader.sv
`timescale 1ns/1ps

module sample_loader (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         byte_valid,
    input  sample_store_pkg::byte_t      rx_byte,
    input  logic                         credit_return,
    output logic                         sample_valid,
    output sample_store_pkg::sample_t    sample,
    output logic                         sample_end,
    output logic                         sample_final,
    output sample_store_pkg::word_addr_t offsets [sample_store_pkg::INSTRUMENT_COUNT],
    output logic                         overrun
);
    import sample_store_pkg::*;

    logic [1:0]          count_bytes;             // 3 means the count is complete.
    count_t              rec_count;
    count_t              full_count;
    count_t              sample_idx;
    logic                hi_phase;
    byte_t               low_byte;
    instr_t              instr;
    instr_t              next_instr;
    logic                loaded;
    logic [CREDIT_W-1:0] credits;
    logic                credit_avail;
    logic                count_byte;
    logic                sample_byte;
    logic                last_sample;
    logic                last_instr;
    logic                record_done;

    assign full_count   = {rx_byte, rec_count[COUNT_W-1:BYTE_W]};
    assign next_instr   = instr + 1'b1;
    assign last_instr   = (instr == instr_t'(INSTRUMENT_COUNT - 1));
    assign count_byte   = byte_valid && !loaded && (count_bytes != 2'd3);
    assign sample_byte  = byte_valid && !loaded && (count_bytes == 2'd3);
    assign last_sample  = (sample_idx == rec_count - 1'b1);
    assign credit_avail = (credits > CREDIT_W'(sample_valid));  // A spent credit is not yet counted.

    // Empty records finish on their last count byte.
    assign record_done = (count_byte && count_bytes == 2'd2 && full_count == '0) ||
                         (sample_byte && hi_phase && last_sample);

    always_ff @(posedge clk) begin
        if (rst) begin
            count_bytes  <= '0;
            rec_count    <= '0;
            sample_idx   <= '0;
            hi_phase     <= 1'b0;
            instr        <= '0;
            loaded       <= 1'b0;
            credits      <= CREDIT_W'(SAMPLE_CREDITS);
            sample_valid <= 1'b0;
            overrun      <= 1'b0;
            for (int i = 0; i < INSTRUMENT_COUNT; i++) begin
                offsets[i] <= '0;
            end
        end else begin
            sample_valid <= 1'b0;
            credits      <= credits - CREDIT_W'(sample_valid) + CREDIT_W'(credit_return);
            if (count_byte) begin
                rec_count   <= full_count;
                count_bytes <= count_bytes + 2'd1;
                sample_idx  <= '0;
                hi_phase    <= 1'b0;
                if (count_bytes == 2'd2 && !last_instr) begin
                    // Next instrument starts after this one's padded words.
                    offsets[next_instr] <= offsets[instr] + word_addr_t'(
                        (full_count + count_t'(SAMPLES_PER_WORD - 1)) >> LANE_W);
                end
            end else if (sample_byte) begin
                hi_phase <= !hi_phase;
                if (hi_phase) begin
                    sample_idx <= sample_idx + 1'b1;
                    if (credit_avail) begin
                        sample_valid <= 1'b1;
                    end else begin
                        overrun <= 1'b1;                     // Sample is lost.
                    end
                end
            end
            if (record_done) begin
                count_bytes <= '0;
                if (last_instr) begin
                    loaded <= 1'b1;
                end else begin
                    instr <= next_instr;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_byte && !hi_phase) begin
            low_byte <= rx_byte;
        end
        if (sample_byte && hi_phase) begin
            sample       <= {rx_byte, low_byte};
            sample_end   <= last_sample;
            sample_final <= last_sample && last_instr;
        end
    end

    credits_bounded: assert property (@(posedge clk) disable iff (rst)
        credits <= CREDIT_W'(SAMPLE_CREDITS));

    valid_needs_credit: assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> credits != '0);

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rx,
    output logic                     byte_valid,
    output sample_store_pkg::byte_t  rx_byte
);
    import sample_store_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t            state;
    logic [2:0]           rx_sync;                // Two sync flops plus edge history.
    logic                 rx_s;
    logic                 falling;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [2:0]           bit_cnt;
    byte_t                shift;

    assign rx_s    = rx_sync[1];
    assign falling = rx_sync[2] & ~rx_sync[1];
    assign rx_byte = shift;                       // Stable until the next data bit.

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RX_IDLE;
            rx_sync    <= '1;
            clk_cnt    <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[1:0], rx};
            byte_valid <= 1'b0;
            clk_cnt    <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (falling) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;   // Glitch goes back to idle.
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
                        shift   <= {rx_s, shift[BYTE_W-1:1]};  // LSB arrives first.
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
                        byte_valid <= rx_s;
                        state      <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/sample_store_pkg.sv
package sample_store_pkg;

    localparam int INSTRUMENT_COUNT = 4;
    localparam int CLKS_PER_BIT     = 16;
    localparam int SAMPLES_PER_WORD = 8;
    localparam int WORD_ADDR_W      = 10;
    localparam int SAMPLE_CREDITS   = 4;

    localparam int BYTE_W     = 8;
    localparam int SAMPLE_W   = 16;
    localparam int COUNT_W    = 24;
    localparam int WORD_W     = SAMPLES_PER_WORD * SAMPLE_W;
    localparam int INSTR_W    = $clog2(INSTRUMENT_COUNT);
    localparam int LANE_W     = $clog2(SAMPLES_PER_WORD);
    localparam int CREDIT_W   = $clog2(SAMPLE_CREDITS + 1);    // Holds 0..SAMPLE_CREDITS.
    localparam int FIFO_PTR_W = $clog2(SAMPLE_CREDITS);
    localparam int CLK_CNT_W  = $clog2(CLKS_PER_BIT);

    typedef logic [BYTE_W-1:0]      byte_t;
    typedef logic [SAMPLE_W-1:0]    sample_t;
    typedef logic [COUNT_W-1:0]     count_t;
    typedef logic [WORD_W-1:0]      word_t;         // Lane 0 in the low bits.
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [INSTR_W-1:0]     instr_t;
    typedef logic [LANE_W-1:0]      lane_t;

endpackage
